/* Bender.yml */
package:
  name: riscii

sources:
  # Package first, then the blocks, then the top level.
  - hdl/coreDefs.sv
  - hdl/regFile.sv
  - hdl/fetchStage.sv
  - hdl/executeStage.sv
  - hdl/coreMemController.sv
  - hdl/core.sv

  - target: test
    files:
      - tests/coreTb.sv

/* hdl/core.sv */
`timescale 1ns/10ps
`default_nettype none

module core (
    input  logic                        i_clk,
    input  logic                        i_reset,
    // Unified memory bus.
    output coreDefs::memReq_t           o_memReq,
    output logic                        o_memReqValid,
    input  logic                        i_memReqReady,
    input  logic                        i_memRspValid,
    input  logic [coreDefs::WORD_W-1:0] i_memRspData,
    // MCU handshake.
    input  logic                        i_pauseRequest,
    output logic                        o_paused,
    output logic                        o_halted
);

    import coreDefs::*;

    // Fetch to execute.
    fetchPkt_t fetchPkt;
    logic      fetchValid;
    logic      fetchReady;
    redirect_t redirect;

    // Stage requests to the controller.
    memReq_t           fetchReq;
    logic              fetchReqValid;
    logic              fetchGrant;
    logic              fetchRspValid;
    logic [WORD_W-1:0] fetchRspData;
    memReq_t           dataReq;
    logic              dataReqValid;
    logic              dataGrant;
    logic              dataRspValid;
    logic [WORD_W-1:0] dataRspData;

    // Register file ports.
    logic [REG_ADDR_W-1:0] rsAddr;
    logic [REG_ADDR_W-1:0] rtAddr;
    logic [WORD_W-1:0]     rsData;
    logic [WORD_W-1:0]     rtData;
    logic                  wrEn;
    logic [REG_ADDR_W-1:0] wrAddr;
    logic [WORD_W-1:0]     wrData;

    logic halted;
    logic fetchIdle;
    logic execIdle;
    logic pausedQ;

    // ----------------------------------------
    // Stages
    // ----------------------------------------

    fetchStage uFetch (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_redirect      (redirect),
        .i_pauseRequest  (i_pauseRequest),
        .i_halted        (halted),
        .o_fetchReq      (fetchReq),
        .o_fetchReqValid (fetchReqValid),
        .i_fetchGrant    (fetchGrant),
        .i_fetchRspValid (fetchRspValid),
        .i_fetchRspData  (fetchRspData),
        .o_fetchPkt      (fetchPkt),
        .o_fetchValid    (fetchValid),
        .i_fetchReady    (fetchReady),
        .o_fetchIdle     (fetchIdle)
    );

    executeStage uExecute (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_fetchPkt     (fetchPkt),
        .i_fetchValid   (fetchValid),
        .o_fetchReady   (fetchReady),
        .o_redirect     (redirect),
        .o_dataReq      (dataReq),
        .o_dataReqValid (dataReqValid),
        .i_dataGrant    (dataGrant),
        .i_dataRspValid (dataRspValid),
        .i_dataRspData  (dataRspData),
        .o_rsAddr       (rsAddr),
        .o_rtAddr       (rtAddr),
        .i_rsData       (rsData),
        .i_rtData       (rtData),
        .o_wrEn         (wrEn),
        .o_wrAddr       (wrAddr),
        .o_wrData       (wrData),
        .o_halted       (halted),
        .o_execIdle     (execIdle)
    );

    regFile uRegs (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_rsAddr (rsAddr),
        .i_rtAddr (rtAddr),
        .o_rsData (rsData),
        .o_rtData (rtData),
        .i_wrEn   (wrEn),
        .i_wrAddr (wrAddr),
        .i_wrData (wrData)
    );

    coreMemController uMemCtrl (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_fetchReq      (fetchReq),
        .i_fetchReqValid (fetchReqValid),
        .o_fetchGrant    (fetchGrant),
        .o_fetchRspValid (fetchRspValid),
        .o_fetchRspData  (fetchRspData),
        .i_dataReq       (dataReq),
        .i_dataReqValid  (dataReqValid),
        .o_dataGrant     (dataGrant),
        .o_dataRspValid  (dataRspValid),
        .o_dataRspData   (dataRspData),
        .o_memReq        (o_memReq),
        .o_memReqValid   (o_memReqValid),
        .i_memReqReady   (i_memReqReady),
        .i_memRspValid   (i_memRspValid),
        .i_memRspData    (i_memRspData)
    );

    // ----------------------------------------
    // Pause handshake
    // ----------------------------------------

    // Paused once both stages have drained.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pausedQ <= 1'b0;
        end else begin
            pausedQ <= i_pauseRequest & fetchIdle & execIdle;
        end
    end

    assign o_paused = pausedQ;
    assign o_halted = halted;

endmodule

`default_nettype wire

/* hdl/coreDefs.sv */
`default_nettype none

package coreDefs;

    // ----------------------------------------
    // Widths fixed by the ISA
    // ----------------------------------------

    // Data word and full memory address.
    localparam int WORD_W = 16;

    // Register index, eight registers.
    localparam int REG_ADDR_W = 3;
    localparam int REG_COUNT = 1 << REG_ADDR_W;

    // Word address inside one half of memory.
    localparam int PC_W = WORD_W - 1;

    // Signed immediate of the I format.
    localparam int IMM_W = 6;

    // ----------------------------------------
    // Instruction encoding
    // ----------------------------------------

    // Top nibble of every word; codes past HALT behave as NOP.
    typedef enum logic [3:0] {
        NOP  = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        AND  = 4'h3,
        XOR  = 4'h4,
        ADDI = 4'h5,
        LW   = 4'h6,
        SW   = 4'h7,
        BEQZ = 4'h8,
        HALT = 4'h9
    } opcode_e;

    // Register format, rd = rs op rt.
    typedef struct packed {
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [2:0]            unused;
    } rType_t;

    // Immediate format, shared by ADDI, LW, SW and BEQZ.
    typedef struct packed {
        opcode_e                 opcode;
        logic [REG_ADDR_W-1:0]   rd;
        logic [REG_ADDR_W-1:0]   rs;
        logic signed [IMM_W-1:0] imm;
    } iType_t;

    // One word, read in whichever format the opcode selects.
    typedef union packed {
        rType_t rFmt;
        iType_t iFmt;
    } instr_u;

    // ----------------------------------------
    // Pipeline and bus records
    // ----------------------------------------

    // Word handed from fetch to execute, with its pc + 1.
    typedef struct packed {
        instr_u          instr;
        logic [PC_W-1:0] pcNext;
    } fetchPkt_t;

    // Taken-branch redirect, valid for one cycle.
    typedef struct packed {
        logic            taken;
        logic [PC_W-1:0] target;
    } redirect_t;

    // Memory request; reads ignore wdata.
    typedef struct packed {
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        logic              write;
    } memReq_t;

endpackage

`default_nettype wire

/* hdl/coreMemController.sv */
`timescale 1ns/10ps
`default_nettype none

module coreMemController (
    input  logic                        i_clk,
    input  logic                        i_reset,
    // Fetch side.
    input  coreDefs::memReq_t           i_fetchReq,
    input  logic                        i_fetchReqValid,
    output logic                        o_fetchGrant,
    output logic                        o_fetchRspValid,
    output logic [coreDefs::WORD_W-1:0] o_fetchRspData,
    // Data side.
    input  coreDefs::memReq_t           i_dataReq,
    input  logic                        i_dataReqValid,
    output logic                        o_dataGrant,
    output logic                        o_dataRspValid,
    output logic [coreDefs::WORD_W-1:0] o_dataRspData,
    // Memory bus.
    output coreDefs::memReq_t           o_memReq,
    output logic                        o_memReqValid,
    input  logic                        i_memReqReady,
    input  logic                        i_memRspValid,
    input  logic [coreDefs::WORD_W-1:0] i_memRspData
);

    import coreDefs::*;

    // Owner kept while the bus stalls a request.
    logic lockQ;
    logic lockDataQ;

    // One read outstanding, and who asked for it.
    logic readPendQ;
    logic readDataQ;

    logic selData;
    logic selValid;
    logic accept;

    // ----------------------------------------
    // Arbitration
    // ----------------------------------------

    // Data wins unless a stalled fetch already owns the bus.
    assign selData  = lockQ ? lockDataQ : i_dataReqValid;
    assign selValid = selData ? i_dataReqValid : i_fetchReqValid;

    // Nothing new goes out until the read returns.
    assign o_memReqValid = selValid & ~readPendQ;
    assign o_memReq      = selData ? i_dataReq : i_fetchReq;
    assign accept        = o_memReqValid & i_memReqReady;

    assign o_dataGrant  = accept & selData;
    assign o_fetchGrant = accept & ~selData;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            lockQ     <= 1'b0;
            lockDataQ <= 1'b0;
            readPendQ <= 1'b0;
            readDataQ <= 1'b0;
        end else begin
            lockQ     <= o_memReqValid & ~i_memReqReady;
            lockDataQ <= selData;
            // Writes get no response.
            if (accept && !o_memReq.write) begin
                readPendQ <= 1'b1;
                readDataQ <= selData;
            end else if (i_memRspValid) begin
                readPendQ <= 1'b0;
            end
        end
    end

    // Response steering.
    assign o_fetchRspValid = i_memRspValid & readPendQ & ~readDataQ;
    assign o_dataRspValid  = i_memRspValid & readPendQ & readDataQ;
    assign o_fetchRspData  = i_memRspData;
    assign o_dataRspData   = i_memRspData;

endmodule

`default_nettype wire

/* hdl/executeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module executeStage (
    input  logic                            i_clk,
    input  logic                            i_reset,
    // From fetch.
    input  coreDefs::fetchPkt_t             i_fetchPkt,
    input  logic                            i_fetchValid,
    output logic                            o_fetchReady,
    // Branch redirect.
    output coreDefs::redirect_t             o_redirect,
    // Data request and response.
    output coreDefs::memReq_t               o_dataReq,
    output logic                            o_dataReqValid,
    input  logic                            i_dataGrant,
    input  logic                            i_dataRspValid,
    input  logic [coreDefs::WORD_W-1:0]     i_dataRspData,
    // Register file.
    output logic [coreDefs::REG_ADDR_W-1:0] o_rsAddr,
    output logic [coreDefs::REG_ADDR_W-1:0] o_rtAddr,
    input  logic [coreDefs::WORD_W-1:0]     i_rsData,
    input  logic [coreDefs::WORD_W-1:0]     i_rtData,
    output logic                            o_wrEn,
    output logic [coreDefs::REG_ADDR_W-1:0] o_wrAddr,
    output logic [coreDefs::WORD_W-1:0]     o_wrData,
    // Status.
    output logic                            o_halted,
    output logic                            o_execIdle
);

    import coreDefs::*;

    // Load/store sequencer states.
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_GRANT = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;

    logic [1:0]            stateQ;
    logic                  haltedQ;
    memReq_t               dataReqQ;
    logic [REG_ADDR_W-1:0] loadRdQ;

    instr_u            instr;
    opcode_e           op;
    logic [WORD_W-1:0] immExt;
    logic [WORD_W-1:0] dataAddr;
    logic [WORD_W-1:0] aluRes;
    logic              aluWrite;
    logic              isMem;
    logic              consume;

    // ----------------------------------------
    // Decode
    // ----------------------------------------

    assign instr  = i_fetchPkt.instr;
    assign op     = instr.rFmt.opcode;
    assign immExt = {{(WORD_W - IMM_W){instr.iFmt.imm[IMM_W-1]}}, instr.iFmt.imm};
    assign isMem  = (op == LW) || (op == SW);

    // rs sits in the same bits in both formats.
    assign o_rsAddr = instr.rFmt.rs;
    // A store reads its data from rd.
    assign o_rtAddr = (op == SW) ? instr.iFmt.rd : instr.rFmt.rt;

    // One instruction per cycle while idle.
    assign o_fetchReady = (stateQ == ST_IDLE) & ~haltedQ;
    assign consume      = i_fetchValid & o_fetchReady;

    // ----------------------------------------
    // ALU and branch
    // ----------------------------------------

    always_comb begin
        aluWrite = 1'b1;
        case (op)
            ADD:  aluRes = i_rsData + i_rtData;
            SUB:  aluRes = i_rsData - i_rtData;
            AND:  aluRes = i_rsData & i_rtData;
            XOR:  aluRes = i_rsData ^ i_rtData;
            ADDI: aluRes = i_rsData + immExt;
            default: begin
                aluRes   = '0;
                aluWrite = 1'b0;
            end
        endcase
    end

    // Taken BEQZ goes to pc + 1 + imm.
    assign o_redirect.taken  = consume & (op == BEQZ) & (i_rsData == '0);
    assign o_redirect.target = i_fetchPkt.pcNext + immExt[PC_W-1:0];

    // Data lives in the upper half.
    assign dataAddr = i_rsData + immExt;

    // ALU result now, or load data when it returns.
    assign o_wrEn   = (consume & aluWrite) | ((stateQ == ST_DATA) & i_dataRspValid);
    assign o_wrAddr = (stateQ == ST_DATA) ? loadRdQ : instr.rFmt.rd;
    assign o_wrData = (stateQ == ST_DATA) ? i_dataRspData : aluRes;

    // ----------------------------------------
    // Load/store FSM and halt
    // ----------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            stateQ  <= ST_IDLE;
            haltedQ <= 1'b0;
        end else begin
            case (stateQ)
                ST_IDLE: begin
                    if (consume && isMem) begin
                        stateQ <= ST_GRANT;
                    end
                    if (consume && (op == HALT)) begin
                        haltedQ <= 1'b1;
                    end
                end
                // A store ends at acceptance.
                ST_GRANT: begin
                    if (i_dataGrant) begin
                        stateQ <= dataReqQ.write ? ST_IDLE : ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (i_dataRspValid) begin
                        stateQ <= ST_IDLE;
                    end
                end
                default: stateQ <= ST_IDLE;
            endcase
        end
    end

    // Request captured at consume, held until granted.
    always_ff @(posedge i_clk) begin
        if (consume && isMem) begin
            dataReqQ.addr  <= {1'b1, dataAddr[PC_W-1:0]};
            dataReqQ.wdata <= i_rtData;
            dataReqQ.write <= (op == SW);
            loadRdQ        <= instr.iFmt.rd;
        end
    end

    assign o_dataReq      = dataReqQ;
    assign o_dataReqValid = (stateQ == ST_GRANT);
    assign o_halted       = haltedQ;
    assign o_execIdle     = (stateQ == ST_IDLE);

endmodule

`default_nettype wire

/* hdl/fetchStage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchStage (
    input  logic                        i_clk,
    input  logic                        i_reset,
    // Branch redirect from execute.
    input  coreDefs::redirect_t         i_redirect,
    // Pause and halt.
    input  logic                        i_pauseRequest,
    input  logic                        i_halted,
    // Instruction request to the controller.
    output coreDefs::memReq_t           o_fetchReq,
    output logic                        o_fetchReqValid,
    input  logic                        i_fetchGrant,
    // Instruction response.
    input  logic                        i_fetchRspValid,
    input  logic [coreDefs::WORD_W-1:0] i_fetchRspData,
    // Hand-off to execute.
    output coreDefs::fetchPkt_t         o_fetchPkt,
    output logic                        o_fetchValid,
    input  logic                        i_fetchReady,
    // Nothing in flight and nothing buffered.
    output logic                        o_fetchIdle
);

    import coreDefs::*;

    // Address of the next word to request.
    logic [PC_W-1:0] pcQ;

    // Request held until the controller grants it.
    logic            reqValidQ;
    logic            reqStaleQ;
    logic [PC_W-1:0] reqAddrQ;

    // Granted read still waiting for its response.
    logic rspPendQ;
    logic rspStaleQ;

    // One-entry instruction buffer.
    fetchPkt_t bufQ;
    logic      bufValidQ;

    logic drain;
    logic inFlight;
    logic issue;
    logic keepRsp;

    // ----------------------------------------
    // Issue and capture conditions
    // ----------------------------------------

    assign drain    = bufValidQ & i_fetchReady;
    // At most one word in flight, held or outstanding.
    assign inFlight = reqValidQ | rspPendQ;
    // New request once the buffer is free, or frees this cycle.
    assign issue    = ~inFlight & (~bufValidQ | drain) & ~i_pauseRequest
                    & ~i_halted & ~i_redirect.taken;
    // Stale words and words arriving with a redirect are dropped.
    assign keepRsp  = i_fetchRspValid & ~rspStaleQ & ~i_redirect.taken & ~i_halted;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pcQ       <= '0;
            reqValidQ <= 1'b0;
            reqStaleQ <= 1'b0;
            rspPendQ  <= 1'b0;
            rspStaleQ <= 1'b0;
            bufValidQ <= 1'b0;
        end else begin
            // Redirect wins over the sequential step.
            if (i_redirect.taken) begin
                pcQ <= i_redirect.target;
            end else if (issue) begin
                pcQ <= pcQ + 1'b1;
            end
            // A held request stays put, it only turns stale.
            if (issue) begin
                reqValidQ <= 1'b1;
                reqStaleQ <= 1'b0;
            end else if (i_fetchGrant || i_halted) begin
                reqValidQ <= 1'b0;
            end else if (i_redirect.taken) begin
                reqStaleQ <= 1'b1;
            end
            // Track the read in memory.
            if (i_fetchGrant) begin
                rspPendQ  <= 1'b1;
                rspStaleQ <= reqStaleQ | i_redirect.taken;
            end else begin
                if (i_fetchRspValid) begin
                    rspPendQ <= 1'b0;
                end
                if (i_redirect.taken) begin
                    rspStaleQ <= 1'b1;
                end
            end
            // Buffer fill and drain.
            if (keepRsp) begin
                bufValidQ <= 1'b1;
            end else if (drain || i_redirect.taken || i_halted) begin
                bufValidQ <= 1'b0;
            end
        end
    end

    // Payload.
    // pcQ already points past the word in flight.
    always_ff @(posedge i_clk) begin
        if (issue) begin
            reqAddrQ <= pcQ;
        end
        if (keepRsp) begin
            bufQ.instr  <= instr_u'(i_fetchRspData);
            bufQ.pcNext <= pcQ;
        end
    end

    // Code lives in the lower half.
    assign o_fetchReq.addr  = {1'b0, reqAddrQ};
    assign o_fetchReq.wdata = '0;
    assign o_fetchReq.write = 1'b0;
    assign o_fetchReqValid  = reqValidQ & ~i_halted;

    assign o_fetchPkt   = bufQ;
    assign o_fetchValid = bufValidQ;
    assign o_fetchIdle  = ~inFlight & ~bufValidQ;

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic                            i_clk,
    input  logic                            i_reset,
    // Two read ports.
    input  logic [coreDefs::REG_ADDR_W-1:0] i_rsAddr,
    input  logic [coreDefs::REG_ADDR_W-1:0] i_rtAddr,
    output logic [coreDefs::WORD_W-1:0]     o_rsData,
    output logic [coreDefs::WORD_W-1:0]     o_rtData,
    // One write port.
    input  logic                            i_wrEn,
    input  logic [coreDefs::REG_ADDR_W-1:0] i_wrAddr,
    input  logic [coreDefs::WORD_W-1:0]     i_wrData
);

    import coreDefs::*;

    logic [WORD_W-1:0] regsQ [REG_COUNT];

    // Writes to r0 are dropped.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regsQ[i] <= '0;
            end
        end else if (i_wrEn && (i_wrAddr != '0)) begin
            regsQ[i_wrAddr] <= i_wrData;
        end
    end

    // Asynchronous reads, r0 forced to zero.
    assign o_rsData = (i_rsAddr == '0) ? '0 : regsQ[i_rsAddr];
    assign o_rtData = (i_rtAddr == '0) ? '0 : regsQ[i_rtAddr];

endmodule

`default_nettype wire

/* riscii.f */
hdl/coreDefs.sv
hdl/regFile.sv
hdl/fetchStage.sv
hdl/executeStage.sv
hdl/coreMemController.sv
hdl/core.sv
tests/coreTb.sv

/* tests/coreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module coreTb;

    import coreDefs::*;

    localparam int TIMEOUT   = 5000;
    localparam int PROGRAMS  = 4;
    localparam int MEM_WORDS = 65536;

    logic              clk;
    logic              reset;
    memReq_t           memReq;
    logic              memReqValid;
    logic              memReqReady;
    logic              memRspValid;
    logic [WORD_W-1:0] memRspData;
    logic              pauseRequest;
    logic              paused;
    logic              halted;

    // Bus memory, and the copy the reference model runs on.
    logic [15:0] mem    [0:MEM_WORDS-1];
    logic [15:0] refMem [0:MEM_WORDS-1];

    // Stores the reference model expects, in bus order.
    logic [15:0] expAddr [$];
    logic [15:0] expData [$];
    int          storeIdx;

    // The single read in flight.
    logic        rspBusy;
    int          rspWait;
    logic [15:0] rspData;

    // Back-pressure tracking.
    logic    stallPrev;
    memReq_t stallReq;

    logic firstReqSeen;
    logic running;
    logic aborted;
    int   mismatchCount;
    int   otherCount;
    int   waited;

    integer seed      = 32'hdd380386;
    integer pauseSeed = 32'hdd380386 ^ 32'h00005a5a;

    core i_core (
        .i_clk          (clk),
        .i_reset        (reset),
        .o_memReq       (memReq),
        .o_memReqValid  (memReqValid),
        .i_memReqReady  (memReqReady),
        .i_memRspValid  (memRspValid),
        .i_memRspData   (memRspData),
        .i_pauseRequest (pauseRequest),
        .o_paused       (paused),
        .o_halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // NOP-class code fill that mixes in every address bit.
    function automatic logic [15:0] codeFill(input logic [15:0] a);
        return {4'h0, a[11:0] ^ {8'h00, a[15:12]}};
    endfunction

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Random body, then stores of r1..r7 to 0x8000 + 4r, then HALT.
    task automatic buildProgram();
        int          len;
        int          kind;
        logic [3:0]  op;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic [5:0]  imm;
        logic [15:0] w;
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (a >= 32768) begin
                mem[a] = $random(seed);
            end else begin
                mem[a] = codeFill(a[15:0]);
            end
        end
        len = 40 + ({$random(seed)} % 24);
        for (int k = 0; k < len; k++) begin
            kind = {$random(seed)} % 16;
            rd   = $random(seed);
            rs   = $random(seed);
            rt   = $random(seed);
            imm  = $random(seed);
            op   = 4'h1 + (kind % 4);
            if (kind < 5) begin
                w = {op, rd, rs, rt, 3'b000};
            end else if (kind < 8) begin
                w = {4'h5, rd, rs, imm};
            end else if (kind < 10) begin
                w = {4'h6, rd, rs, imm};
            end else if (kind < 12) begin
                w = {4'h7, rd, rs, imm};
            end else if (kind < 14) begin
                // Forward offsets only, 0 to 5.
                imm = {$random(seed)} % 6;
                w   = {4'h8, 3'b000, rs, imm};
            end else begin
                w = {4'h0, rd, rs, imm};
            end
            mem[k] = w;
        end
        for (int r = 1; r < 8; r++) begin
            rd  = r;
            imm = 4 * r;
            mem[len + r - 1] = {4'h7, rd, 3'b000, imm};
        end
        mem[len + 7] = 16'h9000;
    endtask

    // ----------------------------------------
    // Reference ISA model
    // ----------------------------------------

    task automatic runModel();
        logic [15:0] regs [0:7];
        logic [14:0] pc;
        logic [15:0] w;
        logic [15:0] immExt;
        logic [15:0] addr;
        logic [15:0] result;
        logic [3:0]  op;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic        done;
        int          steps;
        for (int a = 0; a < MEM_WORDS; a++) begin
            refMem[a] = mem[a];
        end
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        expAddr.delete();
        expData.delete();
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 100000) begin
            w      = refMem[{1'b0, pc}];
            op     = w[15:12];
            rd     = w[11:9];
            rs     = w[8:6];
            rt     = w[5:3];
            immExt = {{10{w[5]}}, w[5:0]};
            // Data always sits in the upper half.
            addr   = {1'b1, regs[rs][14:0] + immExt[14:0]};
            pc     = pc + 1'b1;
            result = '0;
            case (op)
                4'h1: result = regs[rs] + regs[rt];
                4'h2: result = regs[rs] - regs[rt];
                4'h3: result = regs[rs] & regs[rt];
                4'h4: result = regs[rs] ^ regs[rt];
                4'h5: result = regs[rs] + immExt;
                4'h6: result = refMem[addr];
                4'h7: begin
                    refMem[addr] = regs[rd];
                    expAddr.push_back(addr);
                    expData.push_back(regs[rd]);
                end
                4'h8: begin
                    if (regs[rs] == 16'h0000) begin
                        pc = pc + immExt[14:0];
                    end
                end
                4'h9: done = 1'b1;
                default: begin
                end
            endcase
            // ALU ops and loads write rd; r0 stays zero.
            if (op >= 4'h1 && op <= 4'h6 && rd != 3'd0) begin
                regs[rd] = result;
            end
            steps++;
        end
        if (!done) begin
            otherCount++;
            $display("reference model did not reach HALT");
        end
    endtask

    // ----------------------------------------
    // Reset and bus model
    // ----------------------------------------

    task automatic applyReset();
        @(negedge clk);
        reset        = 1'b1;
        memReqReady  = 1'b0;
        memRspValid  = 1'b0;
        memRspData   = '0;
        rspBusy      = 1'b0;
        rspWait      = 0;
        stallPrev    = 1'b0;
        firstReqSeen = 1'b0;
        storeIdx     = 0;
        repeat (4) @(negedge clk);
        checkValue("o_memReqValid", {15'h0, memReqValid}, 16'h0);
        checkValue("o_paused", {15'h0, paused}, 16'h0);
        checkValue("o_halted", {15'h0, halted}, 16'h0);
        reset = 1'b0;
    endtask

    // One cycle of the memory, driven and sampled at the falling edge.
    task automatic busCycle();
        int   delay;
        logic ready;
        @(negedge clk);
        memRspValid = 1'b0;
        memRspData  = $random(seed);
        if (rspBusy) begin
            rspWait--;
            if (rspWait == 0) begin
                memRspValid = 1'b1;
                memRspData  = rspData;
                rspBusy     = 1'b0;
            end
        end
        if (paused && memReqValid) begin
            otherCount++;
            $display("o_memReqValid is high while o_paused is high");
        end
        if (halted && memReqValid) begin
            otherCount++;
            $display("a request is presented after o_halted rose");
        end
        // A stalled request must not change.
        if (stallPrev && !halted) begin
            if (!memReqValid) begin
                otherCount++;
                $display("o_memReqValid dropped while i_memReqReady was low");
            end else if (memReq !== stallReq) begin
                mismatchCount++;
                $display("mismatch o_memReq: got %h, expected %h", memReq, stallReq);
            end
        end
        if (memReqValid && !firstReqSeen) begin
            checkValue("o_memReq.addr", memReq.addr, 16'h0000);
            checkValue("o_memReq.write", {15'h0, memReq.write}, 16'h0);
            firstReqSeen = 1'b1;
        end
        ready       = ($random(seed) & 3) != 0;
        memReqReady = ready;
        if (memReqValid && ready) begin
            if (memReq.write) begin
                if (storeIdx >= expAddr.size()) begin
                    otherCount++;
                    $display("unexpected store to %h beyond the expected sequence",
                             memReq.addr);
                end else begin
                    checkValue("o_memReq.addr", memReq.addr, expAddr[storeIdx]);
                    checkValue("o_memReq.wdata", memReq.wdata, expData[storeIdx]);
                    storeIdx++;
                end
                mem[memReq.addr] = memReq.wdata;
            end else begin
                if (rspBusy) begin
                    otherCount++;
                    $display("a second read was accepted while one was outstanding");
                end
                delay   = 1 + ({$random(seed)} % 4);
                rspData = mem[memReq.addr];
                rspWait = delay;
                rspBusy = 1'b1;
            end
        end
        stallPrev = memReqValid && !ready;
        stallReq  = memReq;
    endtask

    // ----------------------------------------
    // Random pause requests
    // ----------------------------------------

    initial begin
        int pauseWait;
        int hold;
        pauseRequest = 1'b0;
        forever begin
            @(negedge clk);
            if (running && (($random(pauseSeed) & 63) == 0)) begin
                pauseRequest = 1'b1;
                pauseWait    = 0;
                while (!paused && pauseWait < TIMEOUT) begin
                    @(negedge clk);
                    pauseWait++;
                end
                if (!paused) begin
                    otherCount++;
                    $display("o_paused did not rise within %0d cycles", TIMEOUT);
                end
                hold = 1 + ({$random(pauseSeed)} % 8);
                repeat (hold) @(negedge clk);
                pauseRequest = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        reset         = 1'b1;
        memReqReady   = 1'b0;
        memRspValid   = 1'b0;
        memRspData    = '0;
        running       = 1'b0;
        aborted       = 1'b0;
        mismatchCount = 0;
        otherCount    = 0;
        for (int p = 0; p < PROGRAMS && !aborted; p++) begin
            buildProgram();
            runModel();
            applyReset();
            running = 1'b1;
            waited  = 0;
            while (!halted && waited < TIMEOUT) begin
                busCycle();
                waited++;
            end
            if (!halted) begin
                otherCount++;
                $display("timeout: o_halted did not rise in program %0d", p);
                aborted = 1'b1;
            end else begin
                if (storeIdx != expAddr.size()) begin
                    otherCount++;
                    $display("o_halted rose after %0d of %0d stores",
                             storeIdx, expAddr.size());
                end
                // Quiet window after halt.
                repeat (20) busCycle();
            end
            running = 1'b0;
            waited  = 0;
            while (pauseRequest && waited < TIMEOUT) begin
                busCycle();
                waited++;
            end
            if (pauseRequest) begin
                otherCount++;
                $display("timeout: the pause request was not released");
                aborted = 1'b1;
            end
        end
        $display("checks done: %0d mismatches, %0d other errors",
                 mismatchCount, otherCount);
        if (mismatchCount + otherCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
